// File: all.f
rtl/mpu_pkg.sv
rtl/i2c_bit_timer.sv
rtl/i2c_byte_engine.sv
rtl/mpu_sequencer.sv
rtl/sample_assembler.sv
rtl/mpu_reader.sv
verif/mpu_slave_model.sv
verif/tb_mpu_reader.sv

// File: verif/tb_mpu_reader.sv
module tb_mpu_reader
    import mpu_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT_CYCLES    = 4 * QUARTER_DIV;    // COUNT cycles per bus bit
    localparam int SWEEP_TIMEOUT = 2000 * BIT_CYCLES;  // About three sweeps
    localparam int WAKE_TIMEOUT  = 600 * BIT_CYCLES;

    logic       COUNT;
    logic       resetn;
    logic       en;
    wire        sda;
    wire        scl;
    imu_vec_t   gyro;
    imu_vec_t   accel;
    logic       frame_done;

    integer     seed;
    int         errors;
    int         tests_run;
    int         tests_failed;
    logic [7:0] exp_mem [0:255];    // Copy of the slave register file

    // Register order of one sweep
    logic [7:0] sweep_regs [0:11] = '{8'h43, 8'h44, 8'h45, 8'h46, 8'h47, 8'h48,
                                      8'h3B, 8'h3C, 8'h3D, 8'h3E, 8'h3F, 8'h40};

    pullup (sda);
    pullup (scl);

    mpu_reader dut_i (
        .COUNT      (COUNT),
        .resetn     (resetn),
        .en         (en),
        .sda        (sda),
        .scl        (scl),
        .gyro       (gyro),
        .accel      (accel),
        .frame_done (frame_done)
    );

    mpu_slave_model slave_i (
        .COUNT (COUNT),
        .scl   (scl),
        .sda   (sda)
    );

    always #50 COUNT = ~COUNT;

    // -------------------------------------------------------------------------
    // Helpers
    // -------------------------------------------------------------------------
    task automatic load_memory();
        int val;
        for (int a = 0; a < 256; a++) begin
            val = $random(seed);
            exp_mem[a] = val[7:0];
            slave_i.mem[a] = val[7:0];
        end
    endtask

    // High byte at the named register, low byte at the next one
    function automatic logic [15:0] word_at(logic [7:0] high_reg);
        return {exp_mem[high_reg], exp_mem[high_reg + 8'd1]};
    endfunction

    task automatic check_word(string name, logic [15:0] got, logic [15:0] exp);
        if (got !== exp) begin
            $display("FAILED %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic verify_outputs();
        check_word("gyro.x", gyro.x, word_at(GYRO_XOUT_H));
        check_word("gyro.y", gyro.y, word_at(GYRO_XOUT_H + 8'd2));
        check_word("gyro.z", gyro.z, word_at(GYRO_XOUT_H + 8'd4));
        check_word("accel.x", accel.x, word_at(ACCEL_XOUT_H));
        check_word("accel.y", accel.y, word_at(ACCEL_XOUT_H + 8'd2));
        check_word("accel.z", accel.z, word_at(ACCEL_XOUT_H + 8'd4));
    endtask

    task automatic abort_timeout(string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic wait_frame();
        int cycles;
        cycles = 0;
        @(negedge COUNT);
        while (!frame_done) begin
            if (cycles == SWEEP_TIMEOUT) begin
                abort_timeout("frame_done");
            end
            @(negedge COUNT);
            cycles++;
        end
    endtask

    task automatic poll_wake();
        int cycles;
        cycles = 0;
        while (!slave_i.wake_seen) begin
            if (cycles == WAKE_TIMEOUT) begin
                abort_timeout("the wake write at the slave");
            end
            @(negedge COUNT);
            cycles++;
        end
    endtask

    task automatic close_test(string name, int start_errors);
        tests_run++;
        if (errors == start_errors) begin
            $display("%-20s passed", name);
        end else begin
            tests_failed++;
            $display("%-20s failed with %0d errors", name, errors - start_errors);
        end
    endtask

    // -------------------------------------------------------------------------
    // Directed tests
    // -------------------------------------------------------------------------
    task automatic reset_state();
        int start_errors;
        start_errors = errors;
        if (scl !== 1'b1 || sda !== 1'b1) begin
            $display("FAILED %0t: bus not released, scl %b sda %b", $time, scl, sda);
            errors++;
        end
        if (frame_done !== 1'b0) begin
            $display("FAILED %0t: frame_done is %b after reset", $time, frame_done);
            errors++;
        end
        if (gyro !== '0 || accel !== '0) begin
            $display("FAILED %0t: outputs not zero, %h %h", $time, gyro, accel);
            errors++;
        end
        close_test("reset state", start_errors);
    endtask

    task automatic idle_without_en();
        int start_errors;
        int pulses;
        start_errors = errors;
        pulses = 0;
        repeat (2000) begin
            @(negedge COUNT);
            if (frame_done !== 1'b0) begin
                pulses++;
            end
        end
        if (pulses != 0) begin
            $display("FAILED %0t: %0d frame_done pulses while idle", $time, pulses);
            errors++;
        end
        if (slave_i.start_count != 0) begin
            $display("FAILED %0t: slave saw %0d starts while idle", $time,
                     slave_i.start_count);
            errors++;
        end
        close_test("idle without en", start_errors);
    endtask

    task automatic wake_write();
        int start_errors;
        start_errors = errors;
        en = 1'b1;
        poll_wake();
        if (slave_i.wake_data !== 8'h00) begin
            $display("FAILED %0t: wake data %h, expected 00", $time, slave_i.wake_data);
            errors++;
        end
        if (slave_i.wake_log_pos != 0) begin
            $display("FAILED %0t: %0d reads before wake", $time, slave_i.wake_log_pos);
            errors++;
        end
        close_test("wake write", start_errors);
    endtask

    task automatic first_sweep_values();
        int start_errors;
        start_errors = errors;
        wait_frame();
        verify_outputs();
        close_test("first sweep values", start_errors);
    endtask

    task automatic read_order();
        int         start_errors;
        logic [7:0] exp;
        start_errors = errors;
        wait_frame();    // End of the second sweep
        if (slave_i.log_count != 24) begin
            $display("FAILED %0t: %0d reads logged, expected 24", $time, slave_i.log_count);
            errors++;
        end
        for (int i = 0; i < 24; i++) begin
            exp = sweep_regs[i % 12];
            if (slave_i.log_mem[i] !== exp) begin
                $display("FAILED %0t: read %0d was reg %h, expected %h", $time, i,
                         slave_i.log_mem[i], exp);
                errors++;
            end
        end
        close_test("read order", start_errors);
    endtask

    task automatic continuous_update();
        int start_errors;
        start_errors = errors;
        load_memory();
        en = 1'b0;       // Loop keeps running
        wait_frame();
        wait_frame();
        verify_outputs();
        close_test("continuous update", start_errors);
    endtask

    initial begin
        COUNT        = 1'b0;
        resetn       = 1'b0;
        en           = 1'b0;
        seed         = 32'hbfbe_3928;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_memory();
        repeat (10) @(negedge COUNT);
        resetn = 1'b1;
        @(negedge COUNT);

        reset_state();
        idle_without_en();
        wake_write();
        first_sweep_values();
        read_order();
        continuous_update();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verif/mpu_slave_model.sv
module mpu_slave_model
    import mpu_pkg::*;
(
    input  logic COUNT,
    input  wire  scl,
    inout  wire  sda
);
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum logic [2:0] {
        M_IDLE,
        M_ADDR,
        M_PTR,
        M_WDATA,
        M_READ
    } mode_e;

    logic [7:0] mem [0:255];        // Register file
    logic [7:0] log_mem [0:255];    // Register numbers read, in order
    int         log_count    = 0;
    int         start_count  = 0;
    logic       wake_seen    = 1'b0;
    logic [7:0] wake_data    = 8'h00;
    int         wake_log_pos = 0;   // Reads logged before the wake write

    mode_e      mode      = M_IDLE;
    logic       prev_scl  = 1'b1;
    logic       prev_sda  = 1'b1;
    logic [3:0] bit_cnt   = 4'd0;
    logic [7:0] shreg     = 8'h00;
    logic [7:0] tx        = 8'h00;
    logic [7:0] ptr       = 8'h00;
    logic       tx_active = 1'b0;   // Slave is sending a data byte
    logic       sda_drv   = 1'b0;

    assign sda = sda_drv ? 1'b0 : 1'bz;

    // Bus is sampled on the system clock, so edges are seen one cycle late
    always @(posedge COUNT) begin
        if (prev_scl && scl && prev_sda && !sda) begin
            mode        = M_ADDR;    // Start or repeated start
            bit_cnt     = 4'd0;
            tx_active   = 1'b0;
            start_count = start_count + 1;
        end else if (prev_scl && scl && !prev_sda && sda) begin
            mode      = M_IDLE;      // Stop
            tx_active = 1'b0;
        end else if (mode != M_IDLE && !prev_scl && scl) begin
            if (bit_cnt < 4'd8) begin
                shreg = {shreg[6:0], sda};
            end else if (mode == M_READ && tx_active && sda) begin
                mode      = M_IDLE;  // Master NACK ends the read
                tx_active = 1'b0;
            end
            bit_cnt = bit_cnt + 4'd1;
        end else if (mode != M_IDLE && prev_scl && !scl) begin
            if (bit_cnt == 4'd8) begin
                sda_drv <= 1'b0;
                case (mode)
                    M_ADDR: begin
                        if (shreg[7:1] == MPU_ADDR) begin
                            sda_drv <= 1'b1;
                            mode = shreg[0] ? M_READ : M_PTR;
                        end else begin
                            mode = M_IDLE;
                        end
                    end
                    M_PTR: begin
                        ptr = shreg;
                        mode = M_WDATA;
                        sda_drv <= 1'b1;
                    end
                    M_WDATA: begin
                        if (ptr == PWR_MGMT_1) begin
                            wake_seen    = 1'b1;
                            wake_data    = shreg;
                            wake_log_pos = log_count;
                        end
                        mem[ptr] = shreg;
                        ptr = ptr + 8'd1;
                        sda_drv <= 1'b1;
                    end
                    default: ;                   // Master drives the ack bit
                endcase
            end else if (bit_cnt == 4'd9) begin
                sda_drv <= 1'b0;
                bit_cnt = 4'd0;
                if (mode == M_READ) begin
                    tx = mem[ptr];
                    if (log_count < 256) begin
                        log_mem[log_count] = ptr;
                    end
                    log_count = log_count + 1;
                    ptr       = ptr + 8'd1;
                    tx_active = 1'b1;
                    sda_drv <= !tx[7];
                end
            end else if (tx_active) begin
                sda_drv <= !tx[7 - bit_cnt];
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

// File: rtl/mpu_reader.sv
module mpu_reader
    import mpu_pkg::*;
(
    input  logic     COUNT,
    input  logic     resetn,
    input  logic     en,
    inout  wire      sda,
    inout  wire      scl,
    output imu_vec_t gyro,
    output imu_vec_t accel,
    output logic     frame_done
);

    logic       run;
    logic       tick;
    logic [1:0] phase;
    i2c_cmd_t   cmd;
    logic       cmd_valid;
    logic       busy;
    logic       done;
    logic [7:0] rx_byte;
    logic       scl_low;
    logic       sda_low;
    logic       byte_valid;
    axis_sel_t  sel;
    logic [7:0] assembled_byte;

    // Open drain, pull-ups are external
    assign scl = scl_low ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

    i2c_bit_timer timer_i (
        .COUNT  (COUNT),
        .resetn (resetn),
        .run    (run),
        .tick   (tick),
        .phase  (phase)
    );

    i2c_byte_engine engine_i (
        .COUNT     (COUNT),
        .resetn    (resetn),
        .tick      (tick),
        .phase     (phase),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .sda_in    (sda),
        .busy      (busy),
        .done      (done),
        .rx_byte   (rx_byte),
        .scl_low   (scl_low),
        .sda_low   (sda_low)
    );

    mpu_sequencer seq_i (
        .COUNT          (COUNT),
        .resetn         (resetn),
        .en             (en),
        .busy           (busy),
        .done           (done),
        .rx_byte        (rx_byte),
        .run            (run),
        .cmd            (cmd),
        .cmd_valid      (cmd_valid),
        .byte_valid     (byte_valid),
        .sel            (sel),
        .assembled_byte (assembled_byte)
    );

    sample_assembler asm_i (
        .COUNT          (COUNT),
        .resetn         (resetn),
        .byte_valid     (byte_valid),
        .assembled_byte (assembled_byte),
        .sel            (sel),
        .gyro           (gyro),
        .accel          (accel),
        .frame_done     (frame_done)
    );

endmodule

// File: rtl/sample_assembler.sv
module sample_assembler
    import mpu_pkg::*;
(
    input  logic       COUNT,
    input  logic       resetn,
    input  logic       byte_valid,
    input  logic [7:0] assembled_byte,
    input  axis_sel_t  sel,
    output imu_vec_t   gyro,
    output imu_vec_t   accel,
    output logic       frame_done
);

    logic [7:0]  high_q;    // Staged high byte
    logic [15:0] word;

    assign word = {high_q, assembled_byte};

    always_ff @(posedge COUNT) begin
        if (byte_valid && !sel.low) begin
            high_q <= assembled_byte;
        end
    end

    always_ff @(posedge COUNT) begin
        if (!resetn) begin
            gyro       <= '0;
            accel      <= '0;
            frame_done <= 1'b0;
        end else begin
            // Last axis closes the sweep
            frame_done <= byte_valid && sel.low && (sel.axis == 3'(NUM_AXES - 1));
            if (byte_valid && sel.low) begin
                case (sel.axis)
                    3'd0: gyro.x  <= word;
                    3'd1: gyro.y  <= word;
                    3'd2: gyro.z  <= word;
                    3'd3: accel.x <= word;
                    3'd4: accel.y <= word;
                    3'd5: accel.z <= word;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: rtl/mpu_sequencer.sv
module mpu_sequencer
    import mpu_pkg::*;
(
    input  logic       COUNT,
    input  logic       resetn,
    input  logic       en,
    input  logic       busy,
    input  logic       done,
    input  logic [7:0] rx_byte,
    output logic       run,
    output i2c_cmd_t   cmd,
    output logic       cmd_valid,
    output logic       byte_valid,
    output axis_sel_t  sel,
    output logic [7:0] assembled_byte
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAKE,
        S_READ
    } state_e;

    state_e     state;
    logic [2:0] step;        // Operation index within a transfer
    logic [3:0] reg_idx;     // Byte index in the sweep, 0..11
    logic       waiting;     // Command issued, done not yet seen
    logic [7:0] reg_addr;
    logic       op_last;
    logic       read_step;
    axis_sel_t  cur_sel;
    i2c_cmd_t   next_cmd;

    // First half of the sweep is the gyro block
    assign reg_addr = (reg_idx < 4'(NUM_AXES)) ? GYRO_XOUT_H + 8'(reg_idx)
                                                : ACCEL_XOUT_H + 8'(reg_idx) - 8'(NUM_AXES);

    assign op_last   = (state == S_WAKE) ? (step == 3'd4) : (step == 3'd6);
    assign read_step = (state == S_READ) && (step == 3'd5);

    assign cur_sel.axis = reg_idx[3:1];
    assign cur_sel.low  = reg_idx[0];

    // --------------------------------------------------------------------------
    // Operation table
    // --------------------------------------------------------------------------
    always_comb begin
        next_cmd = '{op: OP_STOP, wdata: 8'h00, nack: 1'b1};
        if (state == S_WAKE) begin
            case (step)
                3'd0: next_cmd.op = OP_START;
                3'd1: next_cmd = '{op: OP_WRITE, wdata: {MPU_ADDR, 1'b0}, nack: 1'b1};
                3'd2: next_cmd = '{op: OP_WRITE, wdata: PWR_MGMT_1, nack: 1'b1};
                3'd3: next_cmd = '{op: OP_WRITE, wdata: 8'h00, nack: 1'b1};    // Clear SLEEP
                default: ;
            endcase
        end else begin
            case (step)
                3'd0,
                3'd3: next_cmd.op = OP_START;    // Second one is the repeated start
                3'd1: next_cmd = '{op: OP_WRITE, wdata: {MPU_ADDR, 1'b0}, nack: 1'b1};
                3'd2: next_cmd = '{op: OP_WRITE, wdata: reg_addr, nack: 1'b1};
                3'd4: next_cmd = '{op: OP_WRITE, wdata: {MPU_ADDR, 1'b1}, nack: 1'b1};
                3'd5: next_cmd.op = OP_READ;     // Single byte, so NACK
                default: ;
            endcase
        end
    end

    // --------------------------------------------------------------------------
    // Sequencing
    // --------------------------------------------------------------------------
    always_ff @(posedge COUNT) begin
        if (!resetn) begin
            state      <= S_IDLE;
            step       <= 3'd0;
            reg_idx    <= 4'd0;
            waiting    <= 1'b0;
            run        <= 1'b0;
            cmd_valid  <= 1'b0;
            byte_valid <= 1'b0;
        end else begin
            cmd_valid  <= 1'b0;
            byte_valid <= 1'b0;
            if (state == S_IDLE) begin
                if (en) begin
                    state <= S_WAKE;    // Latched until reset
                    run   <= 1'b1;
                end
            end else if (!waiting && !busy) begin
                cmd_valid <= 1'b1;
                waiting   <= 1'b1;
            end else if (waiting && done) begin
                waiting    <= 1'b0;
                byte_valid <= read_step;
                if (!op_last) begin
                    step <= step + 3'd1;
                end else begin
                    step <= 3'd0;
                    if (state == S_WAKE) begin
                        state <= S_READ;
                    end else if (reg_idx == 4'(2 * NUM_AXES - 1)) begin
                        reg_idx <= 4'd0;    // Sweep complete, start over
                    end else begin
                        reg_idx <= reg_idx + 4'd1;
                    end
                end
            end
        end
    end

    always_ff @(posedge COUNT) begin
        if (!waiting && !busy) begin
            cmd <= next_cmd;
        end
        if (done) begin
            assembled_byte <= rx_byte;
            sel            <= cur_sel;
        end
    end

endmodule

// File: rtl/i2c_byte_engine.sv
module i2c_byte_engine
    import mpu_pkg::*;
(
    input  logic       COUNT,
    input  logic       resetn,
    input  logic       tick,
    input  logic [1:0] phase,
    input  i2c_cmd_t   cmd,
    input  logic       cmd_valid,
    input  logic       sda_in,
    output logic       busy,
    output logic       done,
    output logic [7:0] rx_byte,
    output logic       scl_low,
    output logic       sda_low
);

    i2c_cmd_t   cmd_q;
    logic       active;      // Operation has reached a bit boundary
    logic [3:0] bit_cnt;     // 0..7 data, 8 acknowledge
    logic [7:0] shift_q;
    logic       ack_bit;
    logic       last_bit;

    // SDA level for the bit about to start
    function automatic logic drive_low(i2c_op_e op, logic [3:0] bit_idx,
                                       logic data_bit, logic nack);
        logic low;
        case (op)
            OP_START: low = 1'b0;                                   // Falls in phase 3
            OP_STOP:  low = 1'b1;                                   // Rises in phase 3
            OP_WRITE: low = (bit_idx == 4'd8) ? 1'b0 : !data_bit;   // Slave acks
            default:  low = (bit_idx == 4'd8) ? !nack : 1'b0;
        endcase
        return low;
    endfunction

    assign ack_bit  = (bit_cnt == 4'd8);
    assign last_bit = (cmd_q.op == OP_START || cmd_q.op == OP_STOP) ? 1'b1 : ack_bit;

    // --------------------------------------------------------------------------
    // Control and line shaping
    // tick with phase p ends quarter p, so outputs set here hold for p+1
    // --------------------------------------------------------------------------
    always_ff @(posedge COUNT) begin
        if (!resetn) begin
            busy    <= 1'b0;
            active  <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= 4'd0;
            scl_low <= 1'b0;
            sda_low <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!busy) begin
                busy <= cmd_valid;
            end else if (tick) begin
                if (!active) begin
                    // Wait for the next bit boundary before the first bit
                    if (phase == 2'd3) begin
                        active  <= 1'b1;
                        bit_cnt <= 4'd0;
                        scl_low <= 1'b1;
                        sda_low <= drive_low(cmd_q.op, 4'd0, shift_q[7], cmd_q.nack);
                    end
                end else begin
                    case (phase)
                        2'd1: scl_low <= 1'b0;    // SCL high for phases 2 and 3
                        2'd2: begin
                            if (cmd_q.op == OP_START) begin
                                sda_low <= 1'b1;
                            end else if (cmd_q.op == OP_STOP) begin
                                sda_low <= 1'b0;
                            end
                        end
                        2'd3: begin
                            if (last_bit) begin
                                busy    <= 1'b0;
                                active  <= 1'b0;
                                done    <= 1'b1;
                                scl_low <= (cmd_q.op != OP_STOP);    // Bus held between ops
                            end else begin
                                bit_cnt <= bit_cnt + 4'd1;
                                scl_low <= 1'b1;
                                sda_low <= drive_low(cmd_q.op, bit_cnt + 4'd1, shift_q[6],
                                                     cmd_q.nack);
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // --------------------------------------------------------------------------
    // Data path
    // --------------------------------------------------------------------------
    always_ff @(posedge COUNT) begin
        if (!busy && cmd_valid) begin
            cmd_q   <= cmd;
            shift_q <= cmd.wdata;
        end else if (busy && active && tick) begin
            if (phase == 2'd1 && cmd_q.op == OP_READ && !ack_bit) begin
                shift_q <= {shift_q[6:0], sda_in};    // Sample as SCL is released
            end else if (phase == 2'd3 && cmd_q.op == OP_WRITE) begin
                shift_q <= {shift_q[6:0], 1'b0};
            end
            if (phase == 2'd3 && last_bit && cmd_q.op == OP_READ) begin
                rx_byte <= shift_q;
            end
        end
    end

endmodule

// File: rtl/i2c_bit_timer.sv
module i2c_bit_timer
    import mpu_pkg::*;
(
    input  logic       COUNT,
    input  logic       resetn,
    input  logic       run,
    output logic       tick,
    output logic [1:0] phase
);

    localparam int DIV_W = $clog2(QUARTER_DIV);

    logic [DIV_W-1:0] div_cnt;

    // Last cycle of each quarter bit
    assign tick = run && (div_cnt == DIV_W'(QUARTER_DIV - 1));

    always_ff @(posedge COUNT) begin
        if (!resetn) begin
            div_cnt <= '0;
            phase   <= 2'd0;
        end else if (!run) begin
            // Held at the start of a bit until the sequencer runs
            div_cnt <= '0;
            phase   <= 2'd0;
        end else if (tick) begin
            div_cnt <= '0;
            phase   <= phase + 2'd1;    // Wraps after phase 3
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

// File: rtl/mpu_pkg.sv
package mpu_pkg;

    // --------------------------------------------------------------------------
    // Bus timing and device constants
    // --------------------------------------------------------------------------
    localparam int         QUARTER_DIV  = 8;        // COUNT cycles per quarter bit
    localparam logic [6:0] MPU_ADDR     = 7'h68;    // AD0 tied low
    localparam logic [7:0] PWR_MGMT_1   = 8'h6B;
    localparam logic [7:0] GYRO_XOUT_H  = 8'h43;
    localparam logic [7:0] ACCEL_XOUT_H = 8'h3B;
    localparam int         NUM_AXES     = 6;        // Gyro xyz then accel xyz

    // --------------------------------------------------------------------------
    // Shared types
    // --------------------------------------------------------------------------
    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } i2c_op_e;

    typedef struct packed {
        i2c_op_e    op;
        logic [7:0] wdata;
        logic       nack;    // Ack level after a read byte, 1 releases SDA
    } i2c_cmd_t;

    // Where a received byte lands in the assembler
    typedef struct packed {
        logic [2:0] axis;
        logic       low;
    } axis_sel_t;

    typedef struct packed {
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] z;
    } imu_vec_t;

endpackage
